// ==== flist.f ====
rtl/csr_pkg.sv
rtl/csr_addr_decode.sv
rtl/csr_trap_regs.sv
rtl/csr_timer.sv
rtl/csr_scratch.sv
rtl/csr_read_irq.sv
rtl/csr_unit.sv
dv/csr_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module csr_unit_tb -f flist.f

./obj_dir/Vcsr_unit_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== dv/csr_unit_tb.sv ====
module csr_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import csr_pkg::*;

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_EXC, OP_ERTN, OP_HW, OP_WAIT} op_t;

    typedef struct packed {
        op_t                   op;
        logic [CSR_ADDR_W-1:0] addr;
        csr_word_t             data;
        csr_word_t             exp;
        csr_word_t             crmd;
        csr_word_t             era;
        csr_word_t             eentry;
        logic                  irq;
        logic                  wake;
    } row_t;

    logic        clk;
    logic        aresetn;
    csr_access_t access;
    trap_event_t trap;
    logic [7:0]  hw_int;
    csr_word_t   rdata;
    csr_word_t   crmd;
    csr_word_t   era;
    csr_word_t   eentry;
    logic        irq;
    logic        wake;

    row_t                  rows[$];
    int                    cur_row;
    logic                  table_ready;
    logic [CSR_ADDR_W-1:0] all_regs [15];

    // Reference model state
    csr_word_t  m_crmd;
    csr_word_t  m_prmd;
    csr_word_t  m_ecfg;
    csr_word_t  m_estat;
    csr_word_t  m_era;
    csr_word_t  m_badv;
    csr_word_t  m_eentry;
    csr_word_t  m_tcfg;
    csr_word_t  m_save [4];
    logic [7:0] m_hw;
    logic       m_ti;

    csr_unit i_csr_unit (
        .clk     (clk),
        .aresetn (aresetn),
        .access  (access),
        .trap    (trap),
        .hw_int  (hw_int),
        .rdata   (rdata),
        .crmd    (crmd),
        .era     (era),
        .eentry  (eentry),
        .irq     (irq),
        .wake    (wake)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_failed(string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(string name, csr_word_t got, csr_word_t exp);
        if (got !== exp) begin
            stop_failed($sformatf("** Error: row %0d %s = 0x%h, expected 0x%h",
                                  cur_row, name, got, exp));
        end
    endtask

    function automatic csr_word_t estat_view();
        csr_word_t v;
        v = m_estat;
        v[9:2] = m_hw;
        v[11] = m_ti;
        return v;
    endfunction

    function automatic csr_word_t read_model(logic [CSR_ADDR_W-1:0] addr);
        case (addr)
            CSR_CRMD:   return m_crmd;
            CSR_PRMD:   return m_prmd;
            CSR_ECFG:   return m_ecfg;
            CSR_ESTAT:  return estat_view();
            CSR_ERA:    return m_era;
            CSR_BADV:   return m_badv;
            CSR_EENTRY: return m_eentry;
            CSR_TCFG:   return m_tcfg;
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: return m_save[addr[1:0]];
            default:    return 32'h0;
        endcase
    endfunction

    task automatic write_model(logic [CSR_ADDR_W-1:0] addr, csr_word_t data);
        case (addr)
            CSR_CRMD: begin
                m_crmd = {23'd0, data[8:5], m_crmd[4:3], data[2:0]};
                // DA and PG change only as a legal pair
                if (data[3] ^ data[4]) begin
                    m_crmd[4:3] = data[4:3];
                end
            end
            CSR_PRMD:   m_prmd = data & 32'h0000_0007;
            CSR_ECFG:   m_ecfg = data & 32'h0000_1BFF;
            CSR_ESTAT:  m_estat = (m_estat & ~32'h3) | (data & 32'h3);
            CSR_ERA:    m_era = data;
            CSR_BADV:   m_badv = data;
            CSR_EENTRY: m_eentry = data & 32'hFFFF_FFC0;
            CSR_TCFG:   m_tcfg = data;
            CSR_TICLR:  m_ti = 1'b0;
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: m_save[addr[1:0]] = data;
            default: begin
            end
        endcase
    endtask

    task automatic push_row(op_t op, logic [CSR_ADDR_W-1:0] addr, csr_word_t data,
                            csr_word_t exp);
        row_t      r;
        csr_word_t est;
        est = estat_view();
        r.op = op;
        r.addr = addr;
        r.data = data;
        r.exp = exp;
        r.crmd = m_crmd;
        r.era = m_era;
        r.eentry = m_eentry;
        r.wake = |est[12:0];
        r.irq = m_crmd[2] && (|(m_ecfg[12:0] & est[12:0]));
        rows.push_back(r);
    endtask

    task automatic stage_write(logic [CSR_ADDR_W-1:0] addr, csr_word_t data);
        write_model(addr, data);
        push_row(OP_WRITE, addr, data, read_model(addr));
    endtask

    task automatic expect_read(logic [CSR_ADDR_W-1:0] addr);
        push_row(OP_READ, addr, 32'h0, read_model(addr));
    endtask

    task automatic build_table();
        csr_word_t r;
        all_regs = '{CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_ESTAT, CSR_ERA, CSR_BADV, CSR_EENTRY,
                     CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TCFG, CSR_TVAL,
                     CSR_TICLR, CSR_CRMD};
        m_crmd = 32'h0000_0008;
        m_prmd = '0;
        m_ecfg = '0;
        m_estat = '0;
        m_era = '0;
        m_badv = '0;
        m_eentry = '0;
        m_tcfg = '0;
        m_save = '{default: '0};
        m_hw = '0;
        m_ti = 1'b0;
        foreach (all_regs[i]) begin
            expect_read(all_regs[i]);
        end
        // Timer registers are left alone until the timer section
        foreach (all_regs[i]) begin
            if (all_regs[i] != CSR_TCFG && all_regs[i] != CSR_TVAL && all_regs[i] != CSR_TICLR) begin
                stage_write(all_regs[i], $urandom());
            end
        end
        stage_write(CSR_CRMD, $urandom() | 32'h18);
        stage_write(CSR_CRMD, $urandom() & ~32'h18);
        // Exception entry and return from PLV 3 with IE set
        stage_write(CSR_CRMD, 32'h0000_000F);
        r = $urandom();
        m_prmd = m_crmd & 32'h7;
        m_crmd = m_crmd & ~32'h7;
        m_era = r;
        m_badv = ~r;
        m_estat[21:16] = 6'h0B;
        m_estat[30:22] = 9'h001;
        push_row(OP_EXC, CSR_ERA, r, r);
        expect_read(CSR_CRMD);
        expect_read(CSR_PRMD);
        expect_read(CSR_BADV);
        expect_read(CSR_ESTAT);
        m_crmd[2:0] = m_prmd[2:0];
        push_row(OP_ERTN, CSR_CRMD, 32'h0, m_crmd);
        // Interrupt pending, enable and wake
        stage_write(CSR_ECFG, 32'h0);
        stage_write(CSR_ESTAT, 32'h0);
        stage_write(CSR_CRMD, 32'h0000_000B);
        m_hw = 8'h05;
        push_row(OP_HW, CSR_ESTAT, 32'h05, estat_view());
        stage_write(CSR_ECFG, 32'h4);
        stage_write(CSR_CRMD, 32'h0000_000F);
        m_hw = 8'h00;
        push_row(OP_HW, CSR_ESTAT, 32'h0, estat_view());
        stage_write(CSR_ESTAT, 32'h2);
        stage_write(CSR_ECFG, 32'h6);
        stage_write(CSR_ESTAT, 32'h0);
        stage_write(CSR_ECFG, 32'h0);
        // One-shot timer with INITVAL 3
        stage_write(CSR_TCFG, (32'd3 << 2) | 32'h1);
        push_row(OP_WAIT, CSR_ESTAT, 32'h800, 32'd3 * 4 + 8);
        m_ti = 1'b1;
        expect_read(CSR_ESTAT);
        stage_write(CSR_TICLR, $urandom());
        expect_read(CSR_ESTAT);
        expect_read(CSR_TVAL);
        expect_read(CSR_TVAL);
    endtask

    task automatic run_row(row_t r);
        csr_access_t acc;
        trap_event_t tev;
        logic        hit;
        acc = '0;
        tev = '0;
        hit = 1'b0;
        acc.en = 1'b1;
        acc.addr = r.addr;
        case (r.op)
            OP_WRITE: begin
                acc.wen = 1'b1;
                acc.wdata = r.data;
            end
            OP_EXC: begin
                // Competing software ERA write
                acc.wen = 1'b1;
                acc.wdata = r.data ^ 32'h5A5A_5A5A;
                tev.exception = 1'b1;
                tev.ecode_we = 1'b1;
                tev.ecode = 7'h4B;
                tev.era_we = 1'b1;
                tev.era = r.data;
                tev.badv_we = 1'b1;
                tev.badv = ~r.data;
            end
            OP_ERTN: tev.ertn = 1'b1;
            default: begin
            end
        endcase
        @(posedge clk);
        access <= acc;
        trap <= tev;
        if (r.op == OP_HW) begin
            hw_int <= r.data[7:0];
        end
        @(posedge clk);
        acc.wen = 1'b0;
        acc.wdata = '0;
        access <= acc;
        trap <= '0;
        if (r.op == OP_WAIT) begin
            for (int n = 0; n < int'(r.exp) && !hit; n++) begin
                @(negedge clk);
                hit = |(rdata & r.data);
            end
            if (!hit) begin
                stop_failed($sformatf("Row %0d: ESTAT bits 0x%h did not set within %0d cycles",
                                      cur_row, r.data, r.exp));
            end
        end else begin
            @(negedge clk);
            check_value("rdata", rdata, r.exp);
            check_value("crmd", crmd, r.crmd);
            check_value("era", era, r.era);
            check_value("eentry", eentry, r.eentry);
            check_value("irq", {31'd0, irq}, {31'd0, r.irq});
            check_value("wake", {31'd0, wake}, {31'd0, r.wake});
        end
    endtask

    initial begin
        wait (table_ready);
        repeat (rows.size() * 4 + 2000) @(posedge clk);
        stop_failed("Watchdog timeout, the run took longer than the table allows");
    end

    initial begin
        access = '0;
        trap = '0;
        hw_int = '0;
        aresetn = 1'b0;
        cur_row = 0;
        table_ready = 1'b0;
        void'($urandom(32'hc668));
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        aresetn <= 1'b1;
        foreach (rows[i]) begin
            cur_row = i;
            run_row(rows[i]);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== rtl/csr_unit.sv ====
module csr_unit (
    input  logic                 clk,
    input  logic                 aresetn,
    input  csr_pkg::csr_access_t access,
    input  csr_pkg::trap_event_t trap,
    input  logic [7:0]           hw_int,
    output csr_pkg::csr_word_t   rdata,
    output csr_pkg::csr_word_t   crmd,
    output csr_pkg::csr_word_t   era,
    output csr_pkg::csr_word_t   eentry,
    output logic                 irq,
    output logic                 wake
);
    import csr_pkg::*;

    csr_sel_t                 sel;
    csr_sel_t                 wr;
    csr_word_t                prmd;
    csr_word_t                ecfg;
    csr_word_t                estat;
    csr_word_t                badv;
    csr_word_t                tcfg;
    csr_word_t                tval;
    csr_word_t [SAVE_NUM-1:0] save;
    logic                     timer_int;

    csr_addr_decode i_csr_addr_decode (
        .access (access),
        .sel    (sel),
        .wr     (wr)
    );

    csr_trap_regs i_csr_trap_regs (
        .clk       (clk),
        .aresetn   (aresetn),
        .wr        (wr),
        .wdata     (access.wdata),
        .trap      (trap),
        .hw_int    (hw_int),
        .timer_int (timer_int),
        .crmd      (crmd),
        .prmd      (prmd),
        .ecfg      (ecfg),
        .estat     (estat),
        .era       (era),
        .badv      (badv),
        .eentry    (eentry)
    );

    csr_timer i_csr_timer (
        .clk       (clk),
        .aresetn   (aresetn),
        .wr        (wr),
        .wdata     (access.wdata),
        .tcfg      (tcfg),
        .tval      (tval),
        .timer_int (timer_int)
    );

    csr_scratch i_csr_scratch (
        .clk     (clk),
        .aresetn (aresetn),
        .wr      (wr),
        .wdata   (access.wdata),
        .save    (save)
    );

    csr_read_irq i_csr_read_irq (
        .sel    (sel),
        .crmd   (crmd),
        .prmd   (prmd),
        .ecfg   (ecfg),
        .estat  (estat),
        .era    (era),
        .badv   (badv),
        .eentry (eentry),
        .tcfg   (tcfg),
        .tval   (tval),
        .save   (save),
        .rdata  (rdata),
        .irq    (irq),
        .wake   (wake)
    );

endmodule

// ==== rtl/csr_read_irq.sv ====
module csr_read_irq (
    input  csr_pkg::csr_sel_t                          sel,
    input  csr_pkg::csr_word_t                         crmd,
    input  csr_pkg::csr_word_t                         prmd,
    input  csr_pkg::csr_word_t                         ecfg,
    input  csr_pkg::csr_word_t                         estat,
    input  csr_pkg::csr_word_t                         era,
    input  csr_pkg::csr_word_t                         badv,
    input  csr_pkg::csr_word_t                         eentry,
    input  csr_pkg::csr_word_t                         tcfg,
    input  csr_pkg::csr_word_t                         tval,
    input  csr_pkg::csr_word_t [csr_pkg::SAVE_NUM-1:0] save,
    output csr_pkg::csr_word_t                         rdata,
    output logic                                       irq,
    output logic                                       wake
);
    import csr_pkg::*;

    logic [INT_BITS-1:0] pending;

    // TICLR has no storage and reads as zero
    always_comb begin
        rdata = ({XLEN{sel.crmd}}   & crmd)
              | ({XLEN{sel.prmd}}   & prmd)
              | ({XLEN{sel.ecfg}}   & ecfg)
              | ({XLEN{sel.estat}}  & estat)
              | ({XLEN{sel.era}}    & era)
              | ({XLEN{sel.badv}}   & badv)
              | ({XLEN{sel.eentry}} & eentry)
              | ({XLEN{sel.tcfg}}   & tcfg)
              | ({XLEN{sel.tval}}   & tval);
        for (int i = 0; i < SAVE_NUM; i++) begin
            rdata = rdata | ({XLEN{sel.save[i]}} & save[i]);
        end
    end

    assign pending = estat[INT_BITS-1:0];

    // Idle ends on any pending source, enabled or not
    assign wake = |pending;
    assign irq  = crmd[CRMD_IE] && (|(ecfg[INT_BITS-1:0] & pending));

endmodule

// ==== rtl/csr_scratch.sv ====
module csr_scratch (
    input  logic                                     clk,
    input  logic                                     aresetn,
    input  csr_pkg::csr_sel_t                        wr,
    input  csr_pkg::csr_word_t                       wdata,
    output csr_pkg::csr_word_t [csr_pkg::SAVE_NUM-1:0] save
);
    import csr_pkg::*;

    // Plain storage for the exception handler
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            save <= '0;
        end else begin
            for (int i = 0; i < SAVE_NUM; i++) begin
                if (wr.save[i]) begin
                    save[i] <= wdata;
                end
            end
        end
    end

endmodule

// ==== rtl/csr_timer.sv ====
module csr_timer (
    input  logic               clk,
    input  logic               aresetn,
    input  csr_pkg::csr_sel_t  wr,
    input  csr_pkg::csr_word_t wdata,
    output csr_pkg::csr_word_t tcfg,
    output csr_pkg::csr_word_t tval,
    output logic               timer_int
);
    import csr_pkg::*;

    logic      reload;
    logic      time_out;
    csr_word_t reload_val;

    // One extra count so that INITVAL 0 still fires
    assign reload_val = {tcfg[XLEN-1:TCFG_INITVAL_LSB], 2'b01};

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tcfg   <= '0;
            reload <= 1'b0;
        end else begin
            reload <= wr.tcfg;
            if (wr.tcfg) begin
                tcfg <= wdata & TCFG_MASK;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tval     <= '0;
            time_out <= 1'b0;
        end else if (tval == '0 || reload) begin
            time_out <= 1'b0;
            if (tcfg[TCFG_PERIODIC] || reload) begin
                tval <= reload_val;
            end
        end else if (tcfg[TCFG_EN]) begin
            tval     <= tval - 1'b1;
            time_out <= (tval == 32'd1);
        end
    end

    // Sticky until software writes TICLR
    always_ff @(posedge clk) begin
        if (!aresetn || wr.ticlr) begin
            timer_int <= 1'b0;
        end else if (time_out) begin
            timer_int <= 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!aresetn)
        (!tcfg[TCFG_EN] && !reload && tval != '0) |=> tval == $past(tval))
        else $error("TVAL counted while the timer was disabled");

endmodule

// ==== rtl/csr_trap_regs.sv ====
module csr_trap_regs (
    input  logic                 clk,
    input  logic                 aresetn,
    input  csr_pkg::csr_sel_t    wr,
    input  csr_pkg::csr_word_t   wdata,
    input  csr_pkg::trap_event_t trap,
    input  logic [7:0]           hw_int,
    input  logic                 timer_int,
    output csr_pkg::csr_word_t   crmd,
    output csr_pkg::csr_word_t   prmd,
    output csr_pkg::csr_word_t   ecfg,
    output csr_pkg::csr_word_t   estat,
    output csr_pkg::csr_word_t   era,
    output csr_pkg::csr_word_t   badv,
    output csr_pkg::csr_word_t   eentry
);
    import csr_pkg::*;

    logic [1:0] plv;
    logic       ie;
    logic       da;
    logic       pg;
    logic [1:0] datf;
    logic [1:0] datm;
    logic [1:0] pplv;
    logic       pie;
    csr_word_t  estat_soft;
    logic [7:0] hw_int_q;
    logic [5:0] ecode;
    logic       esubcode;

    // CRMD, ertn wins over exception, exception over software
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            plv  <= CRMD_RESET[CRMD_PLV_LSB +: 2];
            ie   <= CRMD_RESET[CRMD_IE];
            da   <= CRMD_RESET[CRMD_DA];
            pg   <= CRMD_RESET[CRMD_PG];
            datf <= CRMD_RESET[CRMD_DATF_LSB +: 2];
            datm <= CRMD_RESET[CRMD_DATM_LSB +: 2];
        end else if (trap.ertn) begin
            plv <= pplv;
            ie  <= pie;
        end else if (trap.exception) begin
            plv <= 2'd0;
            ie  <= 1'b0;
        end else if (wr.crmd) begin
            plv  <= wdata[CRMD_PLV_LSB +: 2];
            ie   <= wdata[CRMD_IE];
            datf <= wdata[CRMD_DATF_LSB +: 2];
            datm <= wdata[CRMD_DATM_LSB +: 2];
            // Only direct or paged, never both or neither
            if (wdata[CRMD_DA] ^ wdata[CRMD_PG]) begin
                da <= wdata[CRMD_DA];
                pg <= wdata[CRMD_PG];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            pplv <= 2'd0;
            pie  <= 1'b0;
        end else if (trap.exception) begin
            pplv <= plv;
            pie  <= ie;
        end else if (wr.prmd) begin
            pplv <= wdata[PRMD_PPLV_LSB +: 2];
            pie  <= wdata[PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            estat_soft <= '0;
            hw_int_q   <= 8'd0;
            ecode      <= 6'd0;
            esubcode   <= 1'b0;
        end else begin
            hw_int_q <= hw_int;
            if (trap.ecode_we) begin
                ecode    <= trap.ecode[5:0];
                esubcode <= (trap.ecode[5:0] != 6'd0) && trap.ecode[6];
            end else if (wr.estat) begin
                estat_soft <= wdata & ESTAT_SOFT_MASK;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ecfg   <= '0;
            eentry <= '0;
            era    <= '0;
            badv   <= '0;
        end else begin
            if (wr.ecfg) begin
                ecfg <= wdata & ECFG_LIE_MASK;
            end
            if (wr.eentry) begin
                eentry <= wdata & EENTRY_MASK;
            end
            if (trap.era_we) begin
                era <= trap.era;
            end else if (wr.era) begin
                era <= wdata;
            end
            if (trap.badv_we) begin
                badv <= trap.badv;
            end else if (wr.badv) begin
                badv <= wdata;
            end
        end
    end

    always_comb begin
        crmd = '0;
        crmd[CRMD_PLV_LSB +: 2]  = plv;
        crmd[CRMD_IE]            = ie;
        crmd[CRMD_DA]            = da;
        crmd[CRMD_PG]            = pg;
        crmd[CRMD_DATF_LSB +: 2] = datf;
        crmd[CRMD_DATM_LSB +: 2] = datm;
        prmd = '0;
        prmd[PRMD_PPLV_LSB +: 2] = pplv;
        prmd[PRMD_PIE]           = pie;
        // IPI bit stays 0
        estat = estat_soft;
        estat[ESTAT_HW_LSB +: 8]    = hw_int_q;
        estat[ESTAT_TI]             = timer_int;
        estat[ESTAT_ECODE_LSB +: 6] = ecode;
        estat[ESTAT_ESUB_LSB +: 9]  = {8'd0, esubcode};
    end

    assert property (@(posedge clk) disable iff (!aresetn) !(trap.exception && trap.ertn))
        else $error("exception and ertn in the same cycle");

endmodule

// ==== rtl/csr_addr_decode.sv ====
module csr_addr_decode (
    input  csr_pkg::csr_access_t access,
    output csr_pkg::csr_sel_t    sel,
    output csr_pkg::csr_sel_t    wr
);
    import csr_pkg::*;

    logic wr_en;

    assign wr_en = access.en && access.wen;

    always_comb begin
        sel = '0;
        case (access.addr)
            CSR_CRMD:   sel.crmd    = 1'b1;
            CSR_PRMD:   sel.prmd    = 1'b1;
            CSR_ECFG:   sel.ecfg    = 1'b1;
            CSR_ESTAT:  sel.estat   = 1'b1;
            CSR_ERA:    sel.era     = 1'b1;
            CSR_BADV:   sel.badv    = 1'b1;
            CSR_EENTRY: sel.eentry  = 1'b1;
            CSR_SAVE0:  sel.save[0] = 1'b1;
            CSR_SAVE1:  sel.save[1] = 1'b1;
            CSR_SAVE2:  sel.save[2] = 1'b1;
            CSR_SAVE3:  sel.save[3] = 1'b1;
            CSR_TCFG:   sel.tcfg    = 1'b1;
            CSR_TVAL:   sel.tval    = 1'b1;
            CSR_TICLR:  sel.ticlr   = 1'b1;
            default: begin
                // Unmapped address selects nothing
                sel = '0;
            end
        endcase
    end

    // Write strobes only for an enabled write access
    always_comb begin
        wr = '0;
        if (wr_en) begin
            wr = sel;
        end
    end

endmodule

// ==== rtl/csr_pkg.sv ====
package csr_pkg;

    localparam int CSR_ADDR_W = 14;
    localparam int XLEN       = 32;
    localparam int INT_BITS   = 13;
    localparam int SAVE_NUM   = 4;

    typedef logic [XLEN-1:0] csr_word_t;

    // Register address map
    localparam logic [CSR_ADDR_W-1:0] CSR_CRMD   = 14'h000;
    localparam logic [CSR_ADDR_W-1:0] CSR_PRMD   = 14'h001;
    localparam logic [CSR_ADDR_W-1:0] CSR_ECFG   = 14'h004;
    localparam logic [CSR_ADDR_W-1:0] CSR_ESTAT  = 14'h005;
    localparam logic [CSR_ADDR_W-1:0] CSR_ERA    = 14'h006;
    localparam logic [CSR_ADDR_W-1:0] CSR_BADV   = 14'h007;
    localparam logic [CSR_ADDR_W-1:0] CSR_EENTRY = 14'h00C;
    localparam logic [CSR_ADDR_W-1:0] CSR_SAVE0  = 14'h030;
    localparam logic [CSR_ADDR_W-1:0] CSR_SAVE1  = 14'h031;
    localparam logic [CSR_ADDR_W-1:0] CSR_SAVE2  = 14'h032;
    localparam logic [CSR_ADDR_W-1:0] CSR_SAVE3  = 14'h033;
    localparam logic [CSR_ADDR_W-1:0] CSR_TCFG   = 14'h041;
    localparam logic [CSR_ADDR_W-1:0] CSR_TVAL   = 14'h042;
    localparam logic [CSR_ADDR_W-1:0] CSR_TICLR  = 14'h044;

    localparam csr_word_t CRMD_RESET      = 32'h0000_0008;
    localparam csr_word_t ECFG_LIE_MASK   = 32'h0000_1BFF;
    localparam csr_word_t ESTAT_SOFT_MASK = 32'h0000_0003;
    localparam csr_word_t EENTRY_MASK     = 32'hFFFF_FFC0;
    localparam csr_word_t TCFG_MASK       = 32'hFFFF_FFFF;

    // Field positions
    localparam int CRMD_PLV_LSB     = 0;
    localparam int CRMD_IE          = 2;
    localparam int CRMD_DA          = 3;
    localparam int CRMD_PG          = 4;
    localparam int CRMD_DATF_LSB    = 5;
    localparam int CRMD_DATM_LSB    = 7;
    localparam int PRMD_PPLV_LSB    = 0;
    localparam int PRMD_PIE         = 2;
    localparam int ESTAT_HW_LSB     = 2;
    localparam int ESTAT_TI         = 11;
    localparam int ESTAT_ECODE_LSB  = 16;
    localparam int ESTAT_ESUB_LSB   = 22;
    localparam int TCFG_EN          = 0;
    localparam int TCFG_PERIODIC    = 1;
    localparam int TCFG_INITVAL_LSB = 2;

    typedef struct packed {
        logic                  en;
        logic [CSR_ADDR_W-1:0] addr;
        logic                  wen;
        csr_word_t             wdata;
    } csr_access_t;

    // Hardware side of exception entry and return
    typedef struct packed {
        logic       exception;
        logic       ertn;
        logic       ecode_we;
        logic [6:0] ecode;
        logic       era_we;
        csr_word_t  era;
        logic       badv_we;
        csr_word_t  badv;
    } trap_event_t;

    typedef struct packed {
        logic                crmd;
        logic                prmd;
        logic                ecfg;
        logic                estat;
        logic                era;
        logic                badv;
        logic                eentry;
        logic [SAVE_NUM-1:0] save;
        logic                tcfg;
        logic                tval;
        logic                ticlr;
    } csr_sel_t;

endpackage
